// File: cart_loader.f
cart_pkg.sv
cheat_pkg.sv
dl_if.sv
rom_write_ctrl.sv
cart_header_scan.sv
region_select.sv
cheat_code_loader.sv
cart_loader.sv
cart_loader_asserts.sv
cart_loader_checker.sv
tb_cart_loader.sv

// File: run_sim.sh
#!/bin/bash
# Compile and run the cart_loader testbench with Verilator
set -o pipefail

verilator --binary --timing --assert -Wno-fatal --top-module tb_cart_loader \
	-f cart_loader.f -o sim_cart_loader \
	&& ./obj_dir/sim_cart_loader 2>&1 | tee sim.log \
	|| { echo "Build or simulation failed"; exit 1; }

grep -q "FAIL: see errors above" sim.log \
	&& { echo "Simulation reported failure"; exit 1; } \
	|| { echo "Simulation passed"; exit 0; }

// File: tb_cart_loader.sv
/*
 * Testbench for the cartridge loader. Streams a table of header images
 * and a table of cheat codes into the DUT under random memory
 * back-pressure. All comparing is done in the checker beside the DUT.
 */

module tb_cart_loader;

	timeunit 1ns;
	timeprecision 100ps;

	import cart_pkg::*;

	localparam int ADDR_W        = 25;
	localparam int CLK_PERIOD    = 40;
	localparam int RESET_CYCLES  = 8;
	localparam int N_ROWS        = 11;
	localparam int N_CODES       = 3;
	localparam int EXTRA_WORDS   = 4;  // Most words sent past the header end
	localparam int IDLE_CYCLES   = 6;
	localparam int STALL_FACTOR  = 8;  // Worst-case cycles per word
	localparam int HDR_WORDS     = int'(HDR_END) / 2 + 1; // Up to the HDR_END word
	localparam int WORDS_PER_ROW = HDR_WORDS + EXTRA_WORDS; // Longest row
	localparam longint WATCHDOG_NS = longint'(N_ROWS * (WORDS_PER_ROW + IDLE_CYCLES)
		+ N_CODES * 8 + RESET_CYCLES + 64) * STALL_FACTOR * CLK_PERIOD;

	typedef struct {
		string      name;
		serial_t    serial;
		logic [23:0] rgn_bytes;    // Bytes at 0x1F0, 0x1F1, 0x1F2
		logic       auto_rgn;
		logic [1:0] prio;
		logic [7:0] index;
		logic [1:0] exp_region;
		logic       exp_set;
		logic [7:0] exp_quirks;
		logic       exp_gun_type;
		logic [7:0] exp_gun_delay;
	} row_t;

	logic              clk_sys;
	logic              RESET;
	logic              dl_valid, dl_ready, dl_active;
	logic [ADDR_W-1:0] dl_addr;
	logic [15:0]       dl_data;
	logic [7:0]        dl_index;
	logic              mem_valid, mem_ready;
	logic [ADDR_W-2:0] mem_addr;
	logic [15:0]       mem_data;
	logic [ADDR_W-1:0] rom_size;
	logic              region_auto, region_set;
	logic [1:0]        region_prio, region;
	logic [7:0]        quirks, gun_delay;
	logic              gun_type, cheat_valid, cheat_reset;
	logic [127:0]      cheat_code;

	row_t         rows [N_ROWS];
	string        code_names [N_CODES];
	logic [127:0] codes [N_CODES];
	logic [7:0]   image [1024];

	cart_loader #(.ADDR_W(ADDR_W)) u_dut (.*);

	cart_loader_checker #(.ADDR_W(ADDR_W)) u_chk (.*);

	bind cart_loader cart_loader_asserts #(.ADDR_W(ADDR_W)) u_asserts (.*);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	initial begin
		void'($urandom(32'h0fac2b10));
		mem_ready = 1'b0;
		forever begin
			@(negedge clk_sys);
			mem_ready <= ($urandom % 4) != 0; // Stall about one cycle in four
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
		$display("FAIL: see errors above");
		$finish;
	end

	task automatic fill_tables();
		//       name           serial      rgn    auto  prio  index  reg  set quirk gt  delay
		rows[0]  = '{"sram_us",       "T-081276", "JUE", 1'b1, 2'd0, 8'h01, 2'd1, 1'b1, 8'h80, 1'b0, 8'd44};
		rows[1]  = '{"gun_mk1533_eu", "MK-1533 ", "J E", 1'b1, 2'd0, 8'h02, 2'd2, 1'b1, 8'h00, 1'b0, 8'd100};
		rows[2]  = '{"gun_t95096_eu", "T-95096-", "JUE", 1'b1, 2'd1, 8'h03, 2'd2, 1'b1, 8'h00, 1'b1, 8'd52};
		rows[3]  = '{"wildcard_jp",   "T-68123-", "J  ", 1'b1, 2'd2, 8'h04, 2'd0, 1'b1, 8'h01, 1'b0, 8'd44};
		rows[4]  = '{"nibble_digit",  "ABCDEFGH", "4  ", 1'b1, 2'd3, 8'h05, 2'd1, 1'b1, 8'h00, 1'b0, 8'd44};
		rows[5]  = '{"nibble_hex",    "G-4060  ", "C  ", 1'b1, 2'd1, 8'h06, 2'd2, 1'b1, 8'h40, 1'b0, 8'd44};
		rows[6]  = '{"no_flags",      "T-113016", "   ", 1'b1, 2'd2, 8'h07, 2'd1, 1'b1, 8'h20, 1'b0, 8'd44};
		rows[7]  = '{"nibble_eu",     "ABCDEFGH", "8  ", 1'b1, 2'd3, 8'h08, 2'd2, 1'b1, 8'h00, 1'b0, 8'd44};
		rows[8]  = '{"manual_eu",     "T-574023", "JUE", 1'b0, 2'd0, 8'h80, 2'd2, 1'b1, 8'h08, 1'b0, 8'd44};
		rows[9]  = '{"manual_zero",   "ABCDEFGH", "JUE", 1'b0, 2'd0, 8'h00, 2'd0, 1'b0, 8'h00, 1'b0, 8'd44};
		rows[10] = '{"manual_us",     "MK-1229 ", "U  ", 1'b0, 2'd3, 8'h41, 2'd1, 1'b1, 8'h04, 1'b0, 8'd44};
		code_names[0] = "code_first";
		codes[0]      = 128'h0000_0001_00FF_0010_0000_1234_0000_5678;
		code_names[1] = "code_second";
		codes[1]      = 128'hA5A5_0F0F_1234_5678_9ABC_DEF0_CAFE_0001;
		code_names[2] = "code_third";
		codes[2]      = 128'h8000_0000_0020_3FFE_FFFF_0000_0000_FFFF;
	endtask

	// Serial and region bytes over a fill pattern
	task automatic build_image(input row_t r);
		for (int a = 0; a < 1024; a++)
			image[a] = 8'(a ^ (a >> 8) ^ 8'h5A);
		for (int i = 0; i < 8; i++)
			image[int'(HDR_SERIAL_0) + 1 + i] = r.serial[63 - 8*i -: 8];
		image[int'(HDR_REGION_0)]     = r.rgn_bytes[23:16];
		image[int'(HDR_REGION_0) + 1] = r.rgn_bytes[15:8];
		image[int'(HDR_REGION_1)]     = r.rgn_bytes[7:0];
	endtask

	// Starts and ends just after a falling edge
	task automatic send_word(input logic [ADDR_W-1:0] addr, input logic [15:0] data);
		logic accepted;
		accepted = 1'b0;
		dl_valid = 1'b1;
		dl_addr  = addr;
		dl_data  = data;
		while (!accepted) begin
			#1;
			accepted = dl_ready;
			@(posedge clk_sys);
			@(negedge clk_sys);
		end
		dl_valid = 1'b0;
	endtask

	task automatic run_row(input row_t r, input int n_words);
		build_image(r);
		u_chk.set_expect(r.name, r.exp_region, r.exp_set, r.exp_quirks,
			r.exp_gun_type, r.exp_gun_delay);
		dl_index    = r.index;
		region_auto = r.auto_rgn;
		region_prio = r.prio;
		@(negedge clk_sys);
		dl_active = 1'b1;
		@(negedge clk_sys);
		for (int w = 0; w < n_words; w++)
			send_word(ADDR_W'(2 * w), {image[2*w + 1], image[2*w]});
		dl_active = 1'b0;
		repeat (IDLE_CYCLES) @(negedge clk_sys);
	endtask

	// Code word for an even slot with the low half of each field first
	function automatic logic [15:0] code_word(logic [127:0] code, int slot);
		int field;
		int half;
		field = slot / 4;
		half  = (slot / 2) % 2;
		return code[(3 - field) * 32 + half * 16 +: 16];
	endfunction

	task automatic run_codes();
		dl_index = cheat_pkg::CODE_INDEX;
		@(negedge clk_sys);
		dl_active = 1'b1;
		@(negedge clk_sys);
		for (int c = 0; c < N_CODES; c++) begin
			u_chk.expect_code(code_names[c], codes[c]);
			for (int s = 0; s < 16; s += 2)
				send_word(ADDR_W'(16 * c + s), code_word(codes[c], s));
		end
		dl_active = 1'b0;
		repeat (IDLE_CYCLES) @(negedge clk_sys);
	endtask

	initial begin
		RESET       = 1'b1;
		dl_valid    = 1'b0;
		dl_active   = 1'b0;
		dl_addr     = '0;
		dl_data     = '0;
		dl_index    = '0;
		region_auto = 1'b0;
		region_prio = '0;
		fill_tables();
		repeat (RESET_CYCLES) @(posedge clk_sys);
		@(negedge clk_sys);
		RESET = 1'b0;
		repeat (2) @(negedge clk_sys);

		for (int n = 0; n < N_ROWS; n++)
			run_row(rows[n], HDR_WORDS + 1 + n % EXTRA_WORDS); // Lengths differ row to row
		run_codes();
		while (mem_valid) @(negedge clk_sys); // Let the last word drain
		repeat (4) @(negedge clk_sys);

		u_chk.final_check();
		$display("Done: %0d mismatches, %0d other errors", u_chk.mismatches, u_chk.failures);
		if (u_chk.mismatches + u_chk.failures == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// File: cart_loader_checker.sv
/*
 * Watches the loader ports and compares them with expected values.
 * Memory and ROM size expectations come from the accepted stream,
 * header results and cheat codes are set by the testbench.
 */

module cart_loader_checker #(
	parameter int ADDR_W = 25
) (
	input logic              clk_sys,
	input logic              RESET,
	input logic              dl_valid,
	input logic              dl_ready,
	input logic [ADDR_W-1:0] dl_addr,
	input logic [15:0]       dl_data,
	input logic [7:0]        dl_index,
	input logic              dl_active,
	input logic              mem_valid,
	input logic              mem_ready,
	input logic [ADDR_W-2:0] mem_addr,
	input logic [15:0]       mem_data,
	input logic [ADDR_W-1:0] rom_size,
	input logic [1:0]        region,
	input logic              region_set,
	input logic [7:0]        quirks,
	input logic              gun_type,
	input logic [7:0]        gun_delay,
	input logic              cheat_valid,
	input logic [127:0]      cheat_code,
	input logic              cheat_reset
);

	timeunit 1ns;
	timeprecision 100ps;

	import cart_pkg::*;
	import cheat_pkg::*;

	int    mismatches = 0;
	int    failures   = 0;
	string test_name  = "idle";

	logic [1:0] exp_region;
	logic       exp_set;
	logic [7:0] exp_quirks;
	logic       exp_gun_type;
	logic [7:0] exp_gun_delay;

	logic [ADDR_W+14:0] mem_q [$];  // {word address, swapped data}
	logic [127:0]       code_q [$];
	string              code_name_q [$];
	logic [ADDR_W+14:0] mem_exp;
	logic [ADDR_W-1:0]  last_cart_addr = '0;
	logic [ADDR_W-1:0]  size_exp = '0; // Size left by the last finished image
	logic               take;
	logic               active_q  = 1'b0;
	int                 hdr_wait  = 0;
	int                 end_wait  = 0;
	int                 resets_exp  = 0;
	int                 resets_seen = 0;

	task automatic compare_value(input string what, input logic [127:0] exp, act);
		if (exp !== act) begin
			mismatches++;
			$display("Mismatch %s %s: expected %0h, actual %0h", test_name, what, exp, act);
		end
	endtask

	task automatic set_expect(input string name, input logic [1:0] rgn, input logic set,
		input logic [7:0] q, input logic gt, input logic [7:0] gd);
		test_name     = name;
		exp_region    = rgn;
		exp_set       = set;
		exp_quirks    = q;
		exp_gun_type  = gt;
		exp_gun_delay = gd;
	endtask

	task automatic expect_code(input string name, input logic [127:0] code);
		code_name_q.push_back(name);
		code_q.push_back(code);
	endtask

	task automatic final_check();
		test_name = "final";
		if (mem_q.size() != 0) begin
			failures++;
			$display("Error: %0d cartridge words never reached memory", mem_q.size());
		end
		if (code_q.size() != 0) begin
			failures++;
			$display("Error: %0d cheat codes were never presented", code_q.size());
		end
		compare_value("cheat_reset pulses", 128'(resets_exp), 128'(resets_seen));
	endtask

	always @(posedge clk_sys) begin
		if (!RESET) begin
			take = dl_valid & dl_ready;

			if (hdr_wait > 0) begin
				hdr_wait--;
				if (hdr_wait == 0) begin // Two cycles after the HDR_END word
					compare_value("region", 128'(exp_region), 128'(region));
					compare_value("region_set", 128'(exp_set), 128'(region_set));
					compare_value("quirks", 128'(exp_quirks), 128'(quirks));
					compare_value("gun_type", 128'(exp_gun_type), 128'(gun_type));
					compare_value("gun_delay", 128'(exp_gun_delay), 128'(gun_delay));
					compare_value("rom_size held", 128'(size_exp), 128'(rom_size));
				end
			end
			if (end_wait > 0) begin
				end_wait--;
				if (end_wait == 1)
					compare_value("rom_size", 128'(size_exp), 128'(rom_size));
				if (end_wait == 0)
					compare_value("region_set after end", 128'(0), 128'(region_set));
			end

			if (take && dl_index != CODE_INDEX) begin
				mem_q.push_back({dl_addr[ADDR_W-1:1], dl_data[7:0], dl_data[15:8]});
				last_cart_addr = dl_addr;
				if (dl_addr == ADDR_W'(HDR_END))
					hdr_wait = 2;
			end
			if (take && dl_index == CODE_INDEX && dl_addr == '0)
				resets_exp++;
			if (active_q && !dl_active && dl_index != CODE_INDEX) begin
				end_wait = 2;
				size_exp = last_cart_addr;
			end
			active_q = dl_active;

			if (mem_valid && mem_ready) begin
				if (mem_q.size() == 0) begin
					failures++;
					$display("Error: memory write with no cartridge word pending");
				end else begin
					mem_exp = mem_q.pop_front();
					compare_value("mem_addr", 128'(mem_exp[ADDR_W+14:16]), 128'(mem_addr));
					compare_value("mem_data", 128'(mem_exp[15:0]), 128'(mem_data));
				end
			end

			if (cheat_valid) begin
				if (code_q.size() == 0) begin
					failures++;
					$display("Error: cheat_valid pulse with no code expected");
				end else begin
					test_name = code_name_q.pop_front();
					compare_value("cheat_code", code_q.pop_front(), cheat_code);
				end
			end
			if (cheat_reset)
				resets_seen++;
		end
	end

endmodule

// File: cart_loader_asserts.sv
/*
 * Concurrent assertions bound into the loader top level. Covers the
 * memory handshake, dl_ready for code words and one-cycle pulses.
 */

module cart_loader_asserts #(
	parameter int ADDR_W = 25
) (
	input logic              clk_sys,
	input logic              RESET,
	input logic              dl_ready,
	input logic [7:0]        dl_index,
	input logic              mem_valid,
	input logic              mem_ready,
	input logic [ADDR_W-2:0] mem_addr,
	input logic [15:0]       mem_data,
	input logic              cheat_valid,
	input logic              cheat_reset
);

	timeunit 1ns;
	timeprecision 100ps;

	import cheat_pkg::*;

	// Word held until memory takes it
	mem_hold: assert property (@(posedge clk_sys) disable iff (RESET)
		mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) && $stable(mem_data))
		else $error("Memory word changed or dropped while stalled");

	code_ready: assert property (@(posedge clk_sys) disable iff (RESET)
		dl_index == CODE_INDEX |-> dl_ready)
		else $error("dl_ready low for a code word");

	stall_ready: assert property (@(posedge clk_sys) disable iff (RESET)
		mem_valid && !mem_ready && dl_index != CODE_INDEX |-> !dl_ready)
		else $error("Cartridge word accepted while memory buffer full");

	valid_pulse: assert property (@(posedge clk_sys) disable iff (RESET)
		cheat_valid |=> !cheat_valid)
		else $error("cheat_valid high for more than one cycle");

	reset_pulse: assert property (@(posedge clk_sys) disable iff (RESET)
		cheat_reset |=> !cheat_reset)
		else $error("cheat_reset high for more than one cycle");

endmodule

// File: cart_loader.sv
/*
 * Cartridge loader top level. Takes the host download stream, writes
 * cartridge words to ROM memory and derives region, quirks, gun
 * timing and cheat codes from it.
 */

module cart_loader #(
	parameter int ADDR_W = 25
) (
	input  logic              clk_sys,
	input  logic              RESET,

	// Host download stream
	input  logic              dl_valid,
	output logic              dl_ready,
	input  logic [ADDR_W-1:0] dl_addr,
	input  logic [15:0]       dl_data,
	input  logic [7:0]        dl_index,
	input  logic              dl_active,

	// ROM memory write port
	output logic              mem_valid,
	input  logic              mem_ready,
	output logic [ADDR_W-2:0] mem_addr,
	output logic [15:0]       mem_data,
	output logic [ADDR_W-1:0] rom_size,

	// Region control and result
	input  logic              region_auto,
	input  logic [1:0]        region_prio,
	output logic [1:0]        region,
	output logic              region_set,

	output logic [7:0]        quirks,
	output logic              gun_type,
	output logic [7:0]        gun_delay,

	output logic              cheat_valid,
	output logic [127:0]      cheat_code,
	output logic              cheat_reset
);

	logic hdr_ready;
	logic hdr_j, hdr_u, hdr_e;

	dl_if #(.ADDR_W(ADDR_W)) acc ();

	////////////////////////////////////////////////////////////////////
	// Acceptance and memory side
	////////////////////////////////////////////////////////////////////

	rom_write_ctrl #(.ADDR_W(ADDR_W)) u_rom_write_ctrl (
		.clk_sys   (clk_sys),
		.RESET     (RESET),
		.dl_valid  (dl_valid),
		.dl_ready  (dl_ready),
		.dl_addr   (dl_addr),
		.dl_data   (dl_data),
		.dl_index  (dl_index),
		.dl_active (dl_active),
		.acc       (acc.src),
		.mem_valid (mem_valid),
		.mem_ready (mem_ready),
		.mem_addr  (mem_addr),
		.mem_data  (mem_data),
		.rom_size  (rom_size)
	);

	////////////////////////////////////////////////////////////////////
	// Watchers of the accepted stream
	////////////////////////////////////////////////////////////////////

	cart_header_scan u_cart_header_scan (
		.clk_sys   (clk_sys),
		.RESET     (RESET),
		.acc       (acc.mon),
		.hdr_ready (hdr_ready),
		.hdr_j     (hdr_j),
		.hdr_u     (hdr_u),
		.hdr_e     (hdr_e),
		.quirks    (quirks),
		.gun_type  (gun_type),
		.gun_delay (gun_delay)
	);

	region_select u_region_select (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.hdr_ready   (hdr_ready),
		.hdr_j       (hdr_j),
		.hdr_u       (hdr_u),
		.hdr_e       (hdr_e),
		.region_auto (region_auto),
		.region_prio (region_prio),
		.dl_index    (dl_index),
		.region      (region),
		.region_set  (region_set)
	);

	cheat_code_loader u_cheat_code_loader (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.acc         (acc.mon),
		.cheat_valid (cheat_valid),
		.cheat_code  (cheat_code),
		.cheat_reset (cheat_reset)
	);

endmodule

// File: cheat_code_loader.sv
/*
 * Builds cheat codes from code downloads. Each code is eight words,
 * slot taken from address bits 3:0, and the word in the last slot
 * releases the finished code as a one-cycle pulse.
 */

module cheat_code_loader (
	input  logic                  clk_sys,
	input  logic                  RESET,
	dl_if.mon                     acc,
	output logic                  cheat_valid,
	output cheat_pkg::cheat_code_t cheat_code,
	output logic                  cheat_reset
);

	import cheat_pkg::*;

	logic code_take;

	assign code_take = acc.take & acc.is_code;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cheat_valid <= 1'b0;
			cheat_reset <= 1'b0;
		end else begin
			cheat_valid <= code_take && (acc.addr[3:0] == SLOT_REPLACE_HI);
			cheat_reset <= code_take && (acc.addr == '0); // Start of a new code list
		end
	end

	// Fields fill bottom word first
	always_ff @(posedge clk_sys) begin
		if (code_take) begin
			case (acc.addr[3:0])
				SLOT_FLAGS_LO:   cheat_code.f.flags[15:0]    <= acc.data;
				SLOT_FLAGS_HI:   cheat_code.f.flags[31:16]   <= acc.data;
				SLOT_ADDRESS_LO: cheat_code.f.address[15:0]  <= acc.data;
				SLOT_ADDRESS_HI: cheat_code.f.address[31:16] <= acc.data;
				SLOT_COMPARE_LO: cheat_code.f.compare[15:0]  <= acc.data;
				SLOT_COMPARE_HI: cheat_code.f.compare[31:16] <= acc.data;
				SLOT_REPLACE_LO: cheat_code.f.replace[15:0]  <= acc.data;
				SLOT_REPLACE_HI: cheat_code.f.replace[31:16] <= acc.data;
				default: ; // Odd slots carry nothing
			endcase
		end
	end

endmodule

// File: region_select.sv
/*
 * Console region choice. On the rising header-ready flag the region
 * comes from the header flags in the selected priority order, or
 * from the file index bits 7:6 when auto region is off.
 */

module region_select (
	input  logic             clk_sys,
	input  logic             RESET,
	input  logic             hdr_ready,
	input  logic             hdr_j,
	input  logic             hdr_u,
	input  logic             hdr_e,
	input  logic             region_auto,
	input  logic [1:0]       region_prio,
	input  logic [7:0]       dl_index,
	output cart_pkg::region_t region,
	output logic             region_set
);

	import cart_pkg::*;

	logic    ready_q;
	region_t auto_pick;

	// First available region of an order, else the first of the order
	function automatic region_t first_of(logic a_ok, region_t a, logic b_ok, region_t b,
		logic c_ok, region_t c);
		if (a_ok)
			return a;
		else if (b_ok)
			return b;
		else if (c_ok)
			return c;
		return a;
	endfunction

	always_comb begin
		case (region_prio)
			2'd0:    auto_pick = first_of(hdr_u, us, hdr_e, eu, hdr_j, jp); // US>EU>JP
			2'd1:    auto_pick = first_of(hdr_e, eu, hdr_u, us, hdr_j, jp); // EU>US>JP
			2'd2:    auto_pick = first_of(hdr_u, us, hdr_j, jp, hdr_e, eu); // US>JP>EU
			default: auto_pick = first_of(hdr_j, jp, hdr_u, us, hdr_e, eu); // JP>US>EU
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			ready_q    <= 1'b0;
			region     <= jp;
			region_set <= 1'b0;
		end else begin
			ready_q <= hdr_ready;
			if (hdr_ready & ~ready_q) begin
				if (region_auto) begin
					region     <= auto_pick;
					region_set <= 1'b1;
				end else begin
					region     <= region_t'(dl_index[7:6]);
					region_set <= |dl_index; // Index 0 leaves region alone
				end
			end
			if (ready_q & ~hdr_ready)
				region_set <= 1'b0;
		end
	end

endmodule

// File: cart_header_scan.sv
/*
 * Watches cartridge words for the header fields. Collects the serial
 * number and region bytes, looks up quirks and light-gun timing once
 * the serial is complete and flags the header as received at 0x200.
 */

module cart_header_scan (
	input  logic            clk_sys,
	input  logic            RESET,
	dl_if.mon               acc,
	output logic            hdr_ready,
	output logic            hdr_j,
	output logic            hdr_u,
	output logic            hdr_e,
	output cart_pkg::quirk_t quirks,
	output logic            gun_type,
	output logic [7:0]      gun_delay
);

	import cart_pkg::*;

	localparam int N_QUIRK = 12;
	localparam int N_GUN   = 4;

	// Quirk masks in quirk_t order, sram in bit 7 down to schan in bit 0
	localparam serial_t    QUIRK_ID  [N_QUIRK] = '{
		"T-081276", "T-81406 ", "MK-1215 ", "G-4060  ", "T-12046 ", "T-113016",
		"T-89016 ", "T-574023", "MK-1229 ", "G-7001  ", "T-35036 ", "T-68???-"
	};
	localparam logic [7:0] QUIRK_VAL [N_QUIRK] = '{
		8'h80, 8'h80, 8'h40, 8'h40, 8'h40, 8'h20,
		8'h10, 8'h08, 8'h04, 8'h04, 8'h02, 8'h01
	};

	localparam serial_t    GUN_ID   [N_GUN] = '{"MK-1533 ", "T-95096-", "T-95136-", "T-081156"};
	localparam logic       GUN_TYPE [N_GUN] = '{1'b0, 1'b1, 1'b1, 1'b0};
	localparam logic [7:0] GUN_DLY  [N_GUN] = '{8'd100, 8'd52, 8'd30, 8'd126};

	logic       cart_take;
	logic       cart_active;
	logic       active_q;
	serial_t    serial;
	logic [2:0] rgn;       // {e, u, j}
	logic [2:0] rgn_nxt;
	logic [3:0] hrgn;
	logic [7:0] quirk_hit;
	logic       gun_hit_type;
	logic [7:0] gun_hit_dly;

	// Table entry matches, "?" matches any character
	function automatic logic id_match(serial_t id, serial_t pat);
		logic ok;
		ok = 1'b1;
		for (int i = 0; i < 8; i++) begin
			if (pat[i*8 +: 8] != "?" && pat[i*8 +: 8] != id[i*8 +: 8])
				ok = 1'b0;
		end
		return ok;
	endfunction

	function automatic logic [2:0] letter_mask(logic [7:0] c);
		return {c == "E", c == "U", c == "J"};
	endfunction

	assign cart_take   = acc.take & ~acc.is_code;
	assign cart_active = acc.active & ~acc.is_code;
	assign hrgn        = acc.data[3:0] - 4'd7; // 'A'..'F' to 10..15
	assign {hdr_e, hdr_u, hdr_j} = rgn;

	always_comb begin
		quirk_hit    = '0;
		gun_hit_type = 1'b0;
		gun_hit_dly  = GUN_DELAY_DEFAULT;
		for (int i = 0; i < N_QUIRK; i++) begin
			if (id_match(serial, QUIRK_ID[i]))
				quirk_hit = quirk_hit | QUIRK_VAL[i];
		end
		for (int i = N_GUN - 1; i >= 0; i--) begin // First entry wins
			if (id_match(serial, GUN_ID[i])) begin
				gun_hit_type = GUN_TYPE[i];
				gun_hit_dly  = GUN_DLY[i];
			end
		end
	end

	// Region letters, or a hex nibble in the low byte at 0x1F0
	always_comb begin
		rgn_nxt = rgn;
		if (acc.addr == HDR_REGION_0) begin
			if (|letter_mask(acc.data[7:0]))
				rgn_nxt = rgn_nxt | letter_mask(acc.data[7:0]);
			else if (acc.data[7:0] >= "0" && acc.data[7:0] <= "9")
				rgn_nxt = {acc.data[3], acc.data[2], acc.data[0]};
			else if (acc.data[7:0] >= "A" && acc.data[7:0] <= "F")
				rgn_nxt = {hrgn[3], hrgn[2], hrgn[0]};
			rgn_nxt = rgn_nxt | letter_mask(acc.data[15:8]);
		end
		if (acc.addr == HDR_REGION_1)
			rgn_nxt = rgn_nxt | letter_mask(acc.data[7:0]);
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			active_q  <= 1'b0;
			hdr_ready <= 1'b0;
			rgn       <= '0;
			quirks    <= '0;
			gun_type  <= 1'b0;
			gun_delay <= GUN_DELAY_DEFAULT;
		end else begin
			active_q <= cart_active;
			if (cart_active & ~active_q) begin // New image
				rgn    <= '0;
				quirks <= '0;
			end
			if (active_q & ~cart_active)
				hdr_ready <= 1'b0;

			if (cart_take) begin
				rgn <= rgn_nxt;
				if (acc.addr == HDR_LOOKUP) begin
					quirks    <= quirk_hit;
					gun_type  <= gun_hit_type;
					gun_delay <= gun_hit_dly;
				end
				if (acc.addr == HDR_END)
					hdr_ready <= 1'b1;
			end
		end
	end

	// Serial characters shift in from the bottom, first char ends on top
	always_ff @(posedge clk_sys) begin
		if (cart_take) begin
			case (acc.addr)
				HDR_SERIAL_0: serial <= {serial[55:0], acc.data[15:8]};
				HDR_SERIAL_1,
				HDR_SERIAL_2,
				HDR_SERIAL_3: serial <= {serial[47:0], acc.data[7:0], acc.data[15:8]};
				HDR_SERIAL_4: serial <= {serial[55:0], acc.data[7:0]};
				default: ;
			endcase
		end
	end

endmodule

// File: rom_write_ctrl.sv
/*
 * Download acceptance and ROM write path. Cartridge words are byte
 * swapped and held in a one-word buffer until memory takes them.
 * Code words are always accepted and never go to memory.
 */

module rom_write_ctrl #(
	parameter int ADDR_W = 25
) (
	input  logic              clk_sys,
	input  logic              RESET,
	input  logic              dl_valid,
	output logic              dl_ready,
	input  logic [ADDR_W-1:0] dl_addr,
	input  logic [15:0]       dl_data,
	input  logic [7:0]        dl_index,
	input  logic              dl_active,
	dl_if.src                 acc,
	output logic              mem_valid,
	input  logic              mem_ready,
	output logic [ADDR_W-2:0] mem_addr,
	output logic [15:0]       mem_data,
	output logic [ADDR_W-1:0] rom_size
);

	import cheat_pkg::*;

	logic              is_code;
	logic              take;
	logic              cart_take;
	logic              active_q;
	logic [ADDR_W-1:0] last_addr; // Last cartridge byte address seen

	assign is_code   = (dl_index == CODE_INDEX);
	assign dl_ready  = is_code | ~mem_valid | mem_ready; // Buffer free or draining now
	assign take      = dl_valid & dl_ready;
	assign cart_take = take & ~is_code;

	// Publish the accepted word
	assign acc.take    = take;
	assign acc.addr    = dl_addr;
	assign acc.data    = dl_data;
	assign acc.is_code = is_code;
	assign acc.active  = dl_active;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			mem_valid <= 1'b0;
			active_q  <= 1'b0;
			rom_size  <= '0;
		end else begin
			active_q <= dl_active;
			if (cart_take)
				mem_valid <= 1'b1;
			else if (mem_ready)
				mem_valid <= 1'b0; // Word handed over

			if (active_q & ~dl_active)
				rom_size <= last_addr; // End of download
		end
	end

	// Buffered word, loaded only when the buffer is free
	always_ff @(posedge clk_sys) begin
		if (cart_take) begin
			mem_addr  <= dl_addr[ADDR_W-1:1];
			mem_data  <= {dl_data[7:0], dl_data[15:8]};
			last_addr <= dl_addr;
		end
	end

endmodule

// File: dl_if.sv
/*
 * One accepted download word as seen inside the loader. The acceptance
 * logic drives it, the header scan and cheat loader only watch it.
 */

interface dl_if #(
	parameter int ADDR_W = 25
);

	logic              take;    // Word accepted this cycle
	logic [ADDR_W-1:0] addr;    // Byte address
	logic [15:0]       data;
	logic              is_code; // Cheat download, not cartridge
	logic              active;  // Download in progress

	modport src (
		output take, addr, data, is_code, active
	);

	modport mon (
		input take, addr, data, is_code, active
	);

endinterface

// File: cheat_pkg.sv
/*
 * Cheat code format. A code is 128 bits, read either as one flat word
 * or as its four 32-bit fields, and is loaded as eight 16-bit words.
 */

package cheat_pkg;

	// File index reserved for cheat downloads
	localparam logic [7:0] CODE_INDEX = 8'hFF;

	typedef union packed {
		logic [127:0] flat;
		struct packed {
			logic [31:0] flags;   // 127:96
			logic [31:0] address; // 95:64
			logic [31:0] compare; // 63:32
			logic [31:0] replace; // 31:0
		} f;
	} cheat_code_t;

	// Word slots, taken from address bits 3:0 of a code word
	localparam logic [3:0] SLOT_FLAGS_LO   = 4'd0;
	localparam logic [3:0] SLOT_FLAGS_HI   = 4'd2;
	localparam logic [3:0] SLOT_ADDRESS_LO = 4'd4;
	localparam logic [3:0] SLOT_ADDRESS_HI = 4'd6;
	localparam logic [3:0] SLOT_COMPARE_LO = 4'd8;
	localparam logic [3:0] SLOT_COMPARE_HI = 4'd10;
	localparam logic [3:0] SLOT_REPLACE_LO = 4'd12;
	localparam logic [3:0] SLOT_REPLACE_HI = 4'd14; // Completes the code

endpackage

// File: cart_pkg.sv
/*
 * Cartridge image format for the loader. Header byte offsets of the
 * serial number and region fields, the console region encoding and
 * the compatibility quirk flags picked from the serial number.
 */

package cart_pkg;

	////////////////////////////////////////////////////////////////////
	// Header layout, byte addresses as sent by the host
	////////////////////////////////////////////////////////////////////

	localparam logic [15:0] HDR_SERIAL_0 = 16'h0182; // First serial char in high byte
	localparam logic [15:0] HDR_SERIAL_1 = 16'h0184;
	localparam logic [15:0] HDR_SERIAL_2 = 16'h0186;
	localparam logic [15:0] HDR_SERIAL_3 = 16'h0188;
	localparam logic [15:0] HDR_SERIAL_4 = 16'h018A; // Last serial char in low byte
	localparam logic [15:0] HDR_LOOKUP   = 16'h018C; // Serial complete, do the lookup

	localparam logic [15:0] HDR_REGION_0 = 16'h01F0; // Letters or region nibble
	localparam logic [15:0] HDR_REGION_1 = 16'h01F2;
	localparam logic [15:0] HDR_END      = 16'h0200; // Header fully received

	// Sensor delay when the title has no light-gun entry
	localparam logic [7:0] GUN_DELAY_DEFAULT = 8'd44;

	////////////////////////////////////////////////////////////////////
	// Types
	////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		jp = 2'd0,
		us = 2'd1,
		eu = 2'd2
	} region_t;

	// Eight ASCII characters, first character in the top byte
	typedef logic [63:0] serial_t;

	typedef struct packed {
		logic sram;   // Bit 7
		logic eeprom;
		logic noram;
		logic fifo;
		logic pier;
		logic svp;
		logic fmbusy;
		logic schan;  // Bit 0
	} quirk_t;

endpackage
